// File: build.f
+incdir+src
src/core6502_pkg.sv
src/dispatch.sv
src/decoder.sv
src/alu.sv
src/datapath.sv
src/core6502.sv
tests/core6502_assert.sv
tests/core6502_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the core6502 testbench with Verilator, then checks the log for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module core6502_tb -o core6502_sim
./obj_dir/core6502_sim 2>&1 | tee sim.log
if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1

// File: src/alu.sv
// Binary adder and logic ops only, v written by ADC alone and flags held while rdy is low
`timescale 1ns/100ps
`include "core6502_cfg.svh"

module alu import core6502_pkg::*; (
	input logic phi0,
	input logic rstN,
	input logic rdy,
	input ctrlT ctrl,
	input logic [`DATA_W-1:0] aluA,
	input logic [`DATA_W-1:0] aluB,
	output logic [`DATA_W-1:0] aluOut,
	output flagsT flags
);

	logic [`DATA_W:0] sum; // Carry out in the top bit
	logic overflow;

	always_comb begin
		sum = {1'b0, aluA} + {1'b0, aluB} + {{`DATA_W{1'b0}}, ctrl.carryIn};
		// Signed overflow when both inputs agree in sign and the result does not
		overflow = (aluA[`DATA_W-1] == aluB[`DATA_W-1]) &&
			(sum[`DATA_W-1] != aluA[`DATA_W-1]);
		case (ctrl.aluOp)
			aluAdd: aluOut = sum[`DATA_W-1:0];
			aluAnd: aluOut = aluA & aluB;
			aluOr: aluOut = aluA | aluB;
			aluEor: aluOut = aluA ^ aluB;
			aluInc: aluOut = aluB + 1'b1; // INX and INY wrap at 8 bits
			default: aluOut = aluB; // Loads and transfers
		endcase
	end

	always_ff @(posedge phi0) begin
		if (!rstN) begin
			flags <= '0;
		end else if (rdy) begin
			if (ctrl.updNz) begin
				flags.n <= aluOut[`DATA_W-1];
				flags.z <= (aluOut == '0);
			end
			if (ctrl.updC) begin
				flags.c <= sum[`DATA_W]; // ADC carry out
				flags.v <= overflow;
			end else if (ctrl.setC) begin
				flags.c <= 1'b1;
			end else if (ctrl.clrC) begin
				flags.c <= 1'b0;
			end
		end
	end

endmodule

// File: src/core6502.sv
// Single-edge 6502 subset core on phi0 with no interrupts, SO, stack or reset vector fetch
`timescale 1ns/100ps
`include "core6502_cfg.svh"

module core6502 import core6502_pkg::*; (
	input logic phi0, // Reference clock, one bus cycle per rising edge
	input logic rstN,
	input logic rdy, // Low stalls the whole core
	input logic [`DATA_W-1:0] dataIn,
	output logic [`ADDR_W-1:0] addr,
	output logic [`DATA_W-1:0] dataOut,
	output logic rnw, // Low only in a store T2
	output logic sync // High in the opcode fetch
);

	tStateT tState;
	ctrlT ctrl;
	flagsT flags;
	logic [`DATA_W-1:0] ir;
	logic [`DATA_W-1:0] aluA;
	logic [`DATA_W-1:0] aluB;
	logic [`DATA_W-1:0] aluOut;

	dispatch disp (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.ctrl(ctrl),
		.tState(tState),
		.sync(sync)
	);

	decoder dec (
		.ir(ir),
		.tState(tState),
		.flags(flags),
		.ctrl(ctrl)
	);

	alu aluUnit (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.ctrl(ctrl),
		.aluA(aluA),
		.aluB(aluB),
		.aluOut(aluOut),
		.flags(flags)
	);

	datapath dp (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.tState(tState),
		.ctrl(ctrl),
		.dataIn(dataIn),
		.aluOut(aluOut),
		.aluA(aluA),
		.aluB(aluB),
		.ir(ir),
		.addr(addr),
		.dataOut(dataOut),
		.rnw(rnw)
	);

endmodule

// File: src/core6502_cfg.svh
// Start address replaces the reset vector fetch and ADDR_W must stay twice DATA_W for JMP
`ifndef CORE6502_CFG_SVH
`define CORE6502_CFG_SVH

// Program counter value after reset
`define RESET_PC 16'h0200

// Address bus width
`define ADDR_W 16

// Data bus width
`define DATA_W 8

`endif

// File: src/core6502_pkg.sv
// Control word and flag types for the 6502 subset, no decimal mode, no stack, no interrupts
package core6502_pkg;

	// Cycle within an instruction
	typedef enum logic [1:0] {
		T0, // Opcode fetch and completion of the previous op
		T1, // Operand fetch or dummy read
		T2  // Zero page write or JMP high byte
	} tStateT;

	// Operand source for the ALU B side and the store mux
	typedef enum logic [1:0] {
		srcImm,
		srcX,
		srcY,
		srcA
	} srcSelT;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluAnd,
		aluOr,
		aluEor,
		aluInc
	} aluOpT;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v; // Only ADC writes it
	} flagsT;

	typedef struct packed {
		aluOpT aluOp;
		srcSelT srcSel;
		logic loadA;
		logic loadX;
		logic loadY;
		logic setC;
		logic clrC;
		logic updNz;
		logic updC;
		logic carryIn; // Carry into the adder
		srcSelT storeSel;
		logic jmpLo;
		logic jmpHi;
		logic incPc;
		logic lastCycle;
		logic write;
	} ctrlT;

endpackage

// File: src/datapath.sv
// Zero page stores and JMP absolute only; addr, rnw and dataOut depend on state held under rdy low
`timescale 1ns/100ps
`include "core6502_cfg.svh"

module datapath import core6502_pkg::*; (
	input logic phi0,
	input logic rstN,
	input logic rdy,
	input tStateT tState,
	input ctrlT ctrl,
	input logic [`DATA_W-1:0] dataIn,
	input logic [`DATA_W-1:0] aluOut,
	output logic [`DATA_W-1:0] aluA,
	output logic [`DATA_W-1:0] aluB,
	output logic [`DATA_W-1:0] ir,
	output logic [`ADDR_W-1:0] addr,
	output logic [`DATA_W-1:0] dataOut,
	output logic rnw
);

	logic [`DATA_W-1:0] regA;
	logic [`DATA_W-1:0] regX;
	logic [`DATA_W-1:0] regY;
	logic [`ADDR_W-1:0] pc;
	logic [`DATA_W-1:0] dataLatch; // Immediate operand or zero page address
	logic [`DATA_W-1:0] jmpLoByte;

	function automatic logic [`DATA_W-1:0] pickSrc(
		input srcSelT sel,
		input logic [`DATA_W-1:0] imm,
		input logic [`DATA_W-1:0] x,
		input logic [`DATA_W-1:0] y,
		input logic [`DATA_W-1:0] a
	);
		case (sel)
			srcX: return x;
			srcY: return y;
			srcA: return a;
			default: return imm;
		endcase
	endfunction

	// Accumulator always on the A side
	assign aluA = regA;
	assign aluB = pickSrc(ctrl.srcSel, dataLatch, regX, regY, regA);
	assign dataOut = pickSrc(ctrl.storeSel, dataLatch, regX, regY, regA);

	// Store cycle drives the zero page address
	assign addr = ctrl.write ? {{(`ADDR_W - `DATA_W){1'b0}}, dataLatch} : pc;
	assign rnw = !ctrl.write;

	always_ff @(posedge phi0) begin
		if (!rstN) begin
			regA <= '0;
			regX <= '0;
			regY <= '0;
			pc <= `RESET_PC;
			ir <= '0; // BRK slot, decodes as NOP
		end else if (rdy) begin
			if (ctrl.loadA) begin
				regA <= aluOut;
			end
			if (ctrl.loadX) begin
				regX <= aluOut;
			end
			if (ctrl.loadY) begin
				regY <= aluOut;
			end
			if (tState == T0) begin
				ir <= dataIn; // Opcode
			end
			if (ctrl.jmpHi) begin
				pc <= {dataIn, jmpLoByte}; // High byte arrives in T2
			end else if (ctrl.incPc) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Operand latches
	always_ff @(posedge phi0) begin
		if (rdy && tState == T1) begin
			if (ctrl.jmpLo) begin
				jmpLoByte <= dataIn;
			end else begin
				dataLatch <= dataIn;
			end
		end
	end

endmodule

// File: src/decoder.sv
// Only the listed immediate, zero page, implied and JMP opcodes decode and all others run as NOP
`timescale 1ns/100ps
`include "core6502_cfg.svh"

module decoder import core6502_pkg::*; (
	input logic [`DATA_W-1:0] ir,
	input tStateT tState,
	input flagsT flags,
	output ctrlT ctrl
);

	localparam logic [`DATA_W-1:0] opLdaImm = 8'hA9;
	localparam logic [`DATA_W-1:0] opLdxImm = 8'hA2;
	localparam logic [`DATA_W-1:0] opLdyImm = 8'hA0;
	localparam logic [`DATA_W-1:0] opAdcImm = 8'h69;
	localparam logic [`DATA_W-1:0] opAndImm = 8'h29;
	localparam logic [`DATA_W-1:0] opOraImm = 8'h09;
	localparam logic [`DATA_W-1:0] opEorImm = 8'h49;
	localparam logic [`DATA_W-1:0] opStaZp = 8'h85;
	localparam logic [`DATA_W-1:0] opStxZp = 8'h86;
	localparam logic [`DATA_W-1:0] opStyZp = 8'h84;
	localparam logic [`DATA_W-1:0] opTax = 8'hAA;
	localparam logic [`DATA_W-1:0] opTay = 8'hA8;
	localparam logic [`DATA_W-1:0] opInx = 8'hE8;
	localparam logic [`DATA_W-1:0] opIny = 8'hC8;
	localparam logic [`DATA_W-1:0] opClc = 8'h18;
	localparam logic [`DATA_W-1:0] opSec = 8'h38;
	localparam logic [`DATA_W-1:0] opJmpAbs = 8'h4C;

	logic isImm;
	logic isStore;
	logic isJmp;

	assign isImm = ir inside {opLdaImm, opLdxImm, opLdyImm, opAdcImm, opAndImm, opOraImm,
		opEorImm};
	assign isStore = ir inside {opStaZp, opStxZp, opStyZp};
	assign isJmp = (ir == opJmpAbs);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPass;
		ctrl.srcSel = srcImm;
		ctrl.storeSel = srcA;
		case (tState)
			T0: begin
				// ir still holds the previous op, so its register update lands here
				ctrl.incPc = 1'b1;
				ctrl.updNz = isImm || (ir inside {opTax, opTay, opInx, opIny});
				ctrl.loadA = ir inside {opLdaImm, opAdcImm, opAndImm, opOraImm, opEorImm};
				ctrl.loadX = ir inside {opLdxImm, opTax, opInx};
				ctrl.loadY = ir inside {opLdyImm, opTay, opIny};
				ctrl.updC = (ir == opAdcImm);
				ctrl.carryIn = (ir == opAdcImm) && flags.c; // Carry chain for ADC only
				ctrl.setC = (ir == opSec);
				ctrl.clrC = (ir == opClc);
				case (ir)
					opAdcImm: ctrl.aluOp = aluAdd;
					opAndImm: ctrl.aluOp = aluAnd;
					opOraImm: ctrl.aluOp = aluOr;
					opEorImm: ctrl.aluOp = aluEor;
					opTax, opTay: ctrl.srcSel = srcA;
					opInx: begin
						ctrl.aluOp = aluInc;
						ctrl.srcSel = srcX;
					end
					opIny: begin
						ctrl.aluOp = aluInc;
						ctrl.srcSel = srcY;
					end
					default: ctrl.aluOp = aluPass; // Loads pass the operand latch
				endcase
			end
			T1: begin
				ctrl.incPc = isImm || isStore || isJmp; // Implied ops do a dummy read
				ctrl.jmpLo = isJmp;
				ctrl.lastCycle = !(isStore || isJmp);
			end
			default: begin
				ctrl.write = isStore;
				ctrl.jmpHi = isJmp;
				ctrl.lastCycle = 1'b1;
				case (ir)
					opStxZp: ctrl.storeSel = srcX;
					opStyZp: ctrl.storeSel = srcY;
					default: ctrl.storeSel = srcA;
				endcase
			end
		endcase
	end

endmodule

// File: src/dispatch.sv
// Low rdy freezes every state including a write cycle and reset parks in a dead T1 before T0
`timescale 1ns/100ps

module dispatch import core6502_pkg::*; (
	input logic phi0,
	input logic rstN,
	input logic rdy,
	input ctrlT ctrl,
	output tStateT tState,
	output logic sync
);

	tStateT nextState;

	// Only lastCycle matters here
	always_comb begin
		case (tState)
			T0: nextState = T1; // Opcode fetch never ends an op
			T1: begin
				if (ctrl.lastCycle) begin
					nextState = T0;
				end else begin
					nextState = T2;
				end
			end
			default: nextState = T0; // T2 is always last
		endcase
	end

	// The reset state behaves like the tail of a NOP
	always_ff @(posedge phi0) begin
		if (!rstN) begin
			tState <= T1; // Dead cycle so that sync stays low
			sync <= 1'b0;
		end else if (rdy) begin
			tState <= nextState;
			sync <= (nextState == T0); // Registered copy of the fetch cycle
		end
	end

endmodule

// File: tests/core6502_assert.sv
// Bus rules only, sampled on phi0 with rstN synchronous and active low
`timescale 1ns/100ps
`include "core6502_cfg.svh"

module core6502_assert (
	input logic phi0,
	input logic rstN,
	input logic rdy,
	input logic sync,
	input logic rnw,
	input logic [`ADDR_W-1:0] addr
);

	// Opcode fetch is always a read
	fetchIsRead: assert property (@(posedge phi0) disable iff (!rstN) !(sync && !rnw))
		else $error("sync high in a write cycle");

	// Stalled cycle keeps its bus
	holdUnderStall: assert property (@(posedge phi0) disable iff (!rstN)
		!rdy |=> $stable(addr) && $stable(rnw))
		else $error("addr or rnw moved while rdy was low");

	syncLowInReset: assert property (@(posedge phi0) !rstN |=> !sync)
		else $error("sync high during reset");

endmodule

// File: tests/core6502_tb.sv
// Random program from a fixed seed at RESET_PC against an instruction model with zero page stores only
`timescale 1ns/100ps
`include "core6502_cfg.svh"

module core6502_tb;

	localparam int clkPeriod = 4;
	localparam int groupCount = 150;
	localparam logic [7:0] loadOps [3] = '{8'hA9, 8'hA2, 8'hA0}; // LDA LDX LDY immediate
	localparam logic [7:0] storeOps [3] = '{8'h85, 8'h86, 8'h84}; // STA STX STY zero page
	localparam logic [7:0] aluOps [4] = '{8'h69, 8'h29, 8'h09, 8'h49}; // ADC AND ORA EOR
	localparam logic [7:0] moveOps [4] = '{8'hAA, 8'hA8, 8'hE8, 8'hC8}; // TAX TAY INX INY

	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
	} writeT;

	logic phi0 = 1'b0;
	logic rstN;
	logic rdy;
	logic [`DATA_W-1:0] dataIn;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] dataOut;
	logic rnw;
	logic sync;

	logic [`DATA_W-1:0] mem [0:65535];
	integer seed;
	int instrCount = 0;
	int writeCount = 0;
	int modelWriteCount = 0;
	logic genDone = 1'b0;
	logic runDone = 1'b0;
	logic seenFirstFetch = 1'b0;
	logic writeTaken = 1'b0; // Current stalled write already logged
	writeT expWrites[$];
	logic [`DATA_W-1:0] mA;
	logic [`DATA_W-1:0] mX;
	logic [`DATA_W-1:0] mY;
	logic mC;
	logic [`ADDR_W-1:0] mPc;
	logic [`ADDR_W-1:0] endPc; // Address of the final JMP to itself
	logic [`ADDR_W-1:0] genPc;

	core6502 DUT (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.dataIn(dataIn),
		.addr(addr),
		.dataOut(dataOut),
		.rnw(rnw),
		.sync(sync)
	);

	bind core6502 core6502_assert busChecks (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.sync(sync),
		.rnw(rnw),
		.addr(addr)
	);

	always #(clkPeriod / 2) phi0 = ~phi0;

	task automatic checkEq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %0h actual %0h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	function automatic int randRange(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic logic [`DATA_W-1:0] randByte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic emit(input logic [`DATA_W-1:0] b);
		mem[genPc] = b;
		genPc = genPc + 16'd1;
	endtask

	task automatic addLoadStore(input int which);
		emit(loadOps[which]);
		emit(randByte());
		emit(storeOps[which]); // Store back the loaded register
		emit(randByte());
		instrCount += 2;
	endtask

	task automatic addGroup(input int kind);
		int sel;
		int skip;
		logic [`ADDR_W-1:0] target;
		sel = randRange(4);
		case (kind)
			0: addLoadStore(randRange(3));
			1: begin
				if (sel < 2) begin
					emit(sel == 0 ? 8'h18 : 8'h38); // CLC or SEC ahead of the ALU op
					instrCount += 1;
				end
				emit(aluOps[randRange(4)]);
				emit(randByte());
				emit(8'h85); // STA zp
				emit(randByte());
				instrCount += 2;
			end
			2: begin
				emit(moveOps[sel]);
				emit(sel[0] ? 8'h84 : 8'h86); // Y ops to STY, X ops to STX
				emit(randByte());
				instrCount += 2;
			end
			3: begin
				emit(8'hEA); // NOP
				instrCount += 1;
			end
			default: begin
				skip = randRange(4);
				target = genPc + 16'd3 + 16'(skip);
				emit(8'h4C); // JMP abs forward over junk
				emit(target[7:0]);
				emit(target[15:8]);
				repeat (skip) emit(8'hFF);
				instrCount += 1;
			end
		endcase
	endtask

	task automatic pushWrite(input logic [`DATA_W-1:0] zp, input logic [`DATA_W-1:0] value);
		expWrites.push_back({8'h00, zp, value});
		modelWriteCount++;
	endtask

	// Runs one whole instruction of the model at its opcode fetch
	task automatic stepModel();
		logic [`DATA_W-1:0] op;
		logic [`DATA_W-1:0] opd;
		logic [`DATA_W:0] sum;
		checkEq("fetch address", 32'(mPc), 32'(addr));
		if (mPc == endPc) begin
			runDone = 1'b1;
		end else begin
			op = mem[mPc];
			opd = mem[mPc + 16'd1];
			case (op)
				8'hA9: mA = opd;
				8'hA2: mX = opd;
				8'hA0: mY = opd;
				8'h69: begin
					sum = {1'b0, mA} + {1'b0, opd} + {8'd0, mC}; // Binary ADC
					mA = sum[7:0];
					mC = sum[8];
				end
				8'h29: mA = mA & opd;
				8'h09: mA = mA | opd;
				8'h49: mA = mA ^ opd;
				8'h85: pushWrite(opd, mA);
				8'h86: pushWrite(opd, mX);
				8'h84: pushWrite(opd, mY);
				8'hAA: mX = mA;
				8'hA8: mY = mA;
				8'hE8: mX = mX + 8'd1;
				8'hC8: mY = mY + 8'd1;
				8'h18: mC = 1'b0;
				8'h38: mC = 1'b1;
				default: ;
			endcase
			if (op == 8'h4C) begin
				mPc = {mem[mPc + 16'd2], opd};
			end else if (op inside {8'hAA, 8'hA8, 8'hE8, 8'hC8, 8'h18, 8'h38, 8'hEA}) begin
				mPc = mPc + 16'd1; // Implied
			end else begin
				mPc = mPc + 16'd2; // Immediate or zero page
			end
		end
	endtask

	task automatic takeWrite();
		writeT exp;
		if (!writeTaken) begin
			if (expWrites.size() == 0) begin
				$display("Write to %h with data %h while the model expects none", addr, dataOut);
				$display("test failed");
				$fatal(1);
			end
			exp = expWrites.pop_front();
			checkEq("write address", 32'(exp.addr), 32'(addr));
			checkEq("write data", 32'(exp.data), 32'(dataOut));
			mem[addr] = dataOut;
			writeCount++;
		end
		writeTaken = !rdy; // Stalled write repeats next cycle
	endtask

	// Mid-cycle sampling where rdy tells whether the coming edge completes the cycle
	always @(negedge phi0) begin
		if (!runDone) begin
			if (!rstN) begin
				checkEq("sync in reset", 32'd0, 32'(sync));
				checkEq("rnw in reset", 32'd1, 32'(rnw));
			end else begin
				if (sync && !seenFirstFetch) begin
					seenFirstFetch = 1'b1;
					checkEq("first fetch address", 32'(`RESET_PC), 32'(addr));
				end
				if (!rnw) begin
					takeWrite();
				end else begin
					writeTaken = 1'b0;
				end
				if (sync && rdy) begin
					stepModel();
				end
			end
		end
	end

	// Bus inputs change just after the edge
	always @(posedge phi0) begin
		#1;
		rdy = ({$random(seed)} % 5) != 0; // Low about one cycle in five
		dataIn = mem[addr];
	end

	initial begin
		int limit;
		wait (genDone);
		limit = (instrCount * 20 + 16) * clkPeriod;
		#(limit);
		$display("Watchdog expired before the program reached its final JMP");
		$display("test failed");
		$fatal(1);
	end

	initial begin
		seed = 32'h4d86d671;
		rstN = 1'b0;
		rdy = 1'b1;
		dataIn = '0;
		mA = '0;
		mX = '0;
		mY = '0;
		mC = 1'b0; // Flags clear after reset
		mPc = `RESET_PC;
		genPc = `RESET_PC;
		for (int i = 0; i < 65536; i++) begin
			mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5A;
		end
		for (int r = 0; r < 3; r++) begin
			addLoadStore(r); // A, X and Y defined first
		end
		for (int g = 0; g < groupCount; g++) begin
			addGroup(randRange(5));
		end
		endPc = genPc;
		emit(8'h4C); // JMP to itself ends the program
		emit(endPc[7:0]);
		emit(endPc[15:8]);
		instrCount++;
		genDone = 1'b1;
		repeat (4) @(posedge phi0);
		#1;
		rstN = 1'b1;
		wait (runDone);
		checkEq("write count", 32'(modelWriteCount), 32'(writeCount));
		$display("test passed");
		$finish;
	end

endmodule
